/* src/mhq_pkg.sv */
package mhq_pkg;

    // Address and store word sizes of the load/store unit
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // Cache line geometry
    localparam int LINE_BYTES = 16;
    localparam int LINE_W = LINE_BYTES * 8;
    localparam int OFFSET_W = $clog2(LINE_BYTES);
    localparam int line_word_index = LINE_W / WORD_W;

    // Line address, the byte offset inside the line is dropped
    typedef logic [ADDR_W-OFFSET_W-1:0] mhq_addr_t;

    typedef logic [LINE_W-1:0] mhq_line_t;
    typedef logic [WORD_W-1:0] mhq_word_t;
    typedef logic [WORD_W/8-1:0] mhq_bsel_t;
    typedef logic [LINE_BYTES-1:0] mhq_mask_t;

    // Payload of one queue entry, the valid bit is kept beside it
    typedef struct packed {
        logic      dirty;
        mhq_addr_t addr;
        mhq_line_t data;
        mhq_mask_t mask;
    } mhq_entry_t;

endpackage

/* src/mhq_lu.sv */
`timescale 1ns/1ps

module mhq_lu #(
    parameter  int MHQ_DEPTH = 4,
    localparam int TAG_W     = $clog2(MHQ_DEPTH)
) (
    input  logic                                clk,
    input  logic                                i_reset,

    input  logic                                i_lookup_valid,
    input  logic                                i_lookup_dc_hit,
    input  logic [mhq_pkg::ADDR_W-1:0]          i_lookup_addr,
    input  logic                                i_lookup_we,
    input  mhq_pkg::mhq_word_t                  i_lookup_data,
    input  mhq_pkg::mhq_bsel_t                  i_lookup_bsel,

    input  logic [MHQ_DEPTH-1:0]                i_valid_mask,
    input  mhq_pkg::mhq_addr_t [MHQ_DEPTH-1:0]  i_entry_addrs,
    input  logic [TAG_W-1:0]                    i_tail,
    input  logic [TAG_W:0]                      i_count,
    input  logic [TAG_W-1:0]                    i_head_tag,
    input  logic                                i_head_locked,

    output logic                                o_lu_en,
    output logic                                o_lu_we,
    output logic                                o_lu_match,
    output logic [TAG_W-1:0]                    o_lu_tag,
    output mhq_pkg::mhq_addr_t                  o_lu_addr,
    output logic [mhq_pkg::OFFSET_W-1:0]        o_lu_offset,
    output mhq_pkg::mhq_word_t                  o_lu_wr_data,
    output mhq_pkg::mhq_bsel_t                  o_lu_bsel,
    output logic                                o_lookup_done,
    output logic                                o_lookup_retry
);

    mhq_pkg::mhq_addr_t     lookup_line;
    logic [MHQ_DEPTH-1:0]   cam_hit;
    logic [TAG_W-1:0]       cam_tag;
    logic [TAG_W-1:0]       tag;
    logic                   miss;
    logic                   pending_alloc;
    logic                   bypass_hit;
    logic                   match;
    logic                   full;
    logic                   retry;

    assign lookup_line = i_lookup_addr[mhq_pkg::ADDR_W-1:mhq_pkg::OFFSET_W];
    assign miss = i_lookup_valid && !i_lookup_dc_hit;

    // The item in the execute stage is not yet in the entry array
    assign pending_alloc = o_lu_en && !o_lu_match;
    assign bypass_hit = o_lu_en && (o_lu_addr == lookup_line);

    always_comb begin
        cam_tag = '0;
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            cam_hit[i] = i_valid_mask[i] && (i_entry_addrs[i] == lookup_line);
            if (cam_hit[i]) begin
                cam_tag = TAG_W'(i);
            end
        end
    end

    assign match = bypass_hit || (|cam_hit);

    // A new line goes one slot past the tail when an allocation is in flight
    always_comb begin
        if (bypass_hit) begin
            tag = o_lu_tag;
        end else if (|cam_hit) begin
            tag = cam_tag;
        end else if (pending_alloc) begin
            tag = i_tail + 1'b1;
        end else begin
            tag = i_tail;
        end
    end

    assign full = (int'(i_count) + int'(pending_alloc)) >= MHQ_DEPTH;

    // The head line is already on its way from the CCU once it is locked
    assign retry = match ? (i_head_locked && (tag == i_head_tag)) : full;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_lookup_done <= 1'b0;
            o_lu_en <= 1'b0;
        end else begin
            o_lookup_done <= miss;
            o_lu_en <= miss && !retry;
        end
    end

    always_ff @(posedge clk) begin
        o_lookup_retry <= retry;
        o_lu_we <= i_lookup_we;
        o_lu_match <= match;
        o_lu_tag <= tag;
        o_lu_addr <= lookup_line;
        o_lu_offset <= i_lookup_addr[mhq_pkg::OFFSET_W-1:0];
        o_lu_wr_data <= i_lookup_data;
        o_lu_bsel <= i_lookup_bsel;
    end

    // Entries come from the execute stage, so a duplicate line means a merge went wrong
    a_cam_unique: assert property (@(posedge clk) disable iff (i_reset)
        i_lookup_valid |-> $onehot0(cam_hit));

endmodule

/* src/mhq_ex.sv */
`timescale 1ns/1ps

module mhq_ex #(
    parameter  int MHQ_DEPTH = 4,
    localparam int TAG_W     = $clog2(MHQ_DEPTH)
) (
    input  logic                                clk,
    input  logic                                i_reset,

    input  logic                                i_lu_en,
    input  logic                                i_lu_we,
    input  logic                                i_lu_match,
    input  logic [TAG_W-1:0]                    i_lu_tag,
    input  mhq_pkg::mhq_addr_t                  i_lu_addr,
    input  logic [mhq_pkg::OFFSET_W-1:0]        i_lu_offset,
    input  mhq_pkg::mhq_word_t                  i_lu_wr_data,
    input  mhq_pkg::mhq_bsel_t                  i_lu_bsel,
    input  logic                                i_fill_retire,

    output logic [MHQ_DEPTH-1:0]                o_valid_mask,
    output mhq_pkg::mhq_addr_t [MHQ_DEPTH-1:0]  o_entry_addrs,
    output logic [TAG_W-1:0]                    o_tail,
    output logic [TAG_W:0]                      o_count,
    output logic                                o_head_valid,
    output logic [TAG_W-1:0]                    o_head_tag,
    output mhq_pkg::mhq_addr_t                  o_head_addr,
    output mhq_pkg::mhq_line_t                  o_head_data,
    output mhq_pkg::mhq_mask_t                  o_head_mask,
    output logic                                o_head_dirty
);

    localparam int WORD_BYTES = mhq_pkg::WORD_W / 8;
    localparam int WIDX_W = $clog2(mhq_pkg::line_word_index);

    mhq_pkg::mhq_entry_t    entries [MHQ_DEPTH];
    logic [MHQ_DEPTH-1:0]   valid;
    logic [TAG_W-1:0]       head;
    logic [TAG_W-1:0]       tail;
    logic [TAG_W:0]         count;
    logic [WIDX_W-1:0]      word_idx;
    logic                   alloc;
    mhq_pkg::mhq_line_t     wr_line;
    mhq_pkg::mhq_mask_t     wr_mask;

    assign alloc = i_lu_en && !i_lu_match;
    assign word_idx = i_lu_offset[mhq_pkg::OFFSET_W-1 -: WIDX_W];

    // Store word copied into every word slot, the mask picks the one that counts
    assign wr_line = {mhq_pkg::line_word_index{i_lu_wr_data}};
    assign wr_mask = i_lu_we ?
        (mhq_pkg::mhq_mask_t'(i_lu_bsel) << (word_idx * WORD_BYTES)) : '0;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            valid <= '0;
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (alloc) begin
                valid[tail] <= 1'b1;
                tail <= tail + 1'b1;
            end
            if (i_fill_retire) begin
                valid[head] <= 1'b0;
                head <= head + 1'b1;
            end
            count <= count + (TAG_W+1)'(alloc) - (TAG_W+1)'(i_fill_retire);
        end
    end

    // A new entry starts with only the bytes of its first store
    always_ff @(posedge clk) begin
        if (alloc) begin
            entries[tail].addr <= i_lu_addr;
            entries[tail].dirty <= i_lu_we;
            entries[tail].mask <= wr_mask;
            entries[tail].data <= wr_line;
        end else if (i_lu_en && i_lu_we) begin
            entries[i_lu_tag].dirty <= 1'b1;
            entries[i_lu_tag].mask <= entries[i_lu_tag].mask | wr_mask;
            for (int k = 0; k < mhq_pkg::LINE_BYTES; k++) begin
                if (wr_mask[k]) begin
                    entries[i_lu_tag].data[k*8 +: 8] <= wr_line[k*8 +: 8];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            o_entry_addrs[i] = entries[i].addr;
        end
    end

    assign o_valid_mask = valid;
    assign o_tail = tail;
    assign o_count = count;

    assign o_head_valid = valid[head];
    assign o_head_tag = head;
    assign o_head_addr = entries[head].addr;
    assign o_head_data = entries[head].data;
    assign o_head_mask = entries[head].mask;
    assign o_head_dirty = entries[head].dirty;

    // The lookup stage refuses new lines before the queue overflows
    a_alloc_not_full: assert property (@(posedge clk) disable iff (i_reset)
        alloc |-> (int'(count) < MHQ_DEPTH));

    a_retire_valid: assert property (@(posedge clk) disable iff (i_reset)
        i_fill_retire |-> valid[head]);

endmodule

/* src/mhq_fill.sv */
`timescale 1ns/1ps

module mhq_fill #(
    parameter  int MHQ_DEPTH = 4,
    localparam int TAG_W     = $clog2(MHQ_DEPTH)
) (
    input  logic                        clk,
    input  logic                        i_reset,

    input  logic                        i_head_valid,
    input  logic [TAG_W-1:0]            i_head_tag,
    input  mhq_pkg::mhq_addr_t          i_head_addr,
    input  mhq_pkg::mhq_line_t          i_head_data,
    input  mhq_pkg::mhq_mask_t          i_head_mask,
    input  logic                        i_head_dirty,

    input  logic                        i_ccu_done,
    input  mhq_pkg::mhq_line_t          i_ccu_data,
    output logic                        o_ccu_en,
    output logic [mhq_pkg::ADDR_W-1:0]  o_ccu_addr,

    output logic                        o_head_locked,
    output logic                        o_fill_retire,
    output logic                        o_fill_en,
    output logic [TAG_W-1:0]            o_fill_tag,
    output logic [mhq_pkg::ADDR_W-1:0]  o_fill_addr,
    output logic                        o_fill_dirty,
    output mhq_pkg::mhq_line_t          o_fill_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQUEST,
        ST_FILL
    } fill_state_t;

    fill_state_t            state;
    mhq_pkg::mhq_line_t     merged_line;

    // Bytes written by stores win over the line that came back
    always_comb begin
        for (int k = 0; k < mhq_pkg::LINE_BYTES; k++) begin
            merged_line[k*8 +: 8] = i_head_mask[k] ? i_head_data[k*8 +: 8] : i_ccu_data[k*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_head_valid) begin
                        state <= ST_REQUEST;
                    end
                end
                ST_REQUEST: begin
                    if (i_ccu_done) begin
                        state <= ST_FILL;
                    end
                end
                // The old head is gone by now, so the next one can be requested at once
                ST_FILL: state <= i_head_valid ? ST_REQUEST : ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_fill_retire) begin
            o_fill_tag <= i_head_tag;
            o_fill_addr <= {i_head_addr, {mhq_pkg::OFFSET_W{1'b0}}};
            o_fill_dirty <= i_head_dirty;
            o_fill_data <= merged_line;
        end
    end

    assign o_ccu_en = (state == ST_REQUEST);
    assign o_ccu_addr = {i_head_addr, {mhq_pkg::OFFSET_W{1'b0}}};
    assign o_head_locked = (state == ST_REQUEST);
    assign o_fill_retire = (state == ST_REQUEST) && i_ccu_done;
    assign o_fill_en = (state == ST_FILL);

    // The CCU answers only a request that is still held
    a_done_outstanding: assert property (@(posedge clk) disable iff (i_reset)
        i_ccu_done |-> (state == ST_REQUEST));

endmodule

/* src/mhq.sv */
`timescale 1ns/1ps

module mhq #(
    parameter  int MHQ_DEPTH = 4,
    localparam int TAG_W     = $clog2(MHQ_DEPTH)
) (
    input  logic                        clk,
    input  logic                        i_reset,

    input  logic                        i_lookup_valid,
    input  logic                        i_lookup_dc_hit,
    input  logic [mhq_pkg::ADDR_W-1:0]  i_lookup_addr,
    input  logic                        i_lookup_we,
    input  mhq_pkg::mhq_word_t          i_lookup_data,
    input  mhq_pkg::mhq_bsel_t          i_lookup_bsel,
    output logic                        o_lookup_done,
    output logic [TAG_W-1:0]            o_lookup_tag,
    output logic                        o_lookup_retry,

    input  logic                        i_ccu_done,
    input  mhq_pkg::mhq_line_t          i_ccu_data,
    output logic                        o_ccu_en,
    output logic [mhq_pkg::ADDR_W-1:0]  o_ccu_addr,

    output logic                        o_fill_en,
    output logic [TAG_W-1:0]            o_fill_tag,
    output logic [mhq_pkg::ADDR_W-1:0]  o_fill_addr,
    output logic                        o_fill_dirty,
    output mhq_pkg::mhq_line_t          o_fill_data
);

    logic                                lu_en;
    logic                                lu_we;
    logic                                lu_match;
    logic [TAG_W-1:0]                    lu_tag;
    mhq_pkg::mhq_addr_t                  lu_addr;
    logic [mhq_pkg::OFFSET_W-1:0]        lu_offset;
    mhq_pkg::mhq_word_t                  lu_wr_data;
    mhq_pkg::mhq_bsel_t                  lu_bsel;

    logic [MHQ_DEPTH-1:0]                ex_valid_mask;
    mhq_pkg::mhq_addr_t [MHQ_DEPTH-1:0]  ex_entry_addrs;
    logic [TAG_W-1:0]                    ex_tail;
    logic [TAG_W:0]                      ex_count;

    logic                                head_valid;
    logic [TAG_W-1:0]                    head_tag;
    mhq_pkg::mhq_addr_t                  head_addr;
    mhq_pkg::mhq_line_t                  head_data;
    mhq_pkg::mhq_mask_t                  head_mask;
    logic                                head_dirty;
    logic                                head_locked;
    logic                                fill_retire;

    // The tag handed to the execute stage is the one reported back to the LSU
    assign o_lookup_tag = lu_tag;

    mhq_lu #(
        .MHQ_DEPTH(MHQ_DEPTH)
    ) u_lu (
        .clk(clk),
        .i_reset(i_reset),
        .i_lookup_valid(i_lookup_valid),
        .i_lookup_dc_hit(i_lookup_dc_hit),
        .i_lookup_addr(i_lookup_addr),
        .i_lookup_we(i_lookup_we),
        .i_lookup_data(i_lookup_data),
        .i_lookup_bsel(i_lookup_bsel),
        .i_valid_mask(ex_valid_mask),
        .i_entry_addrs(ex_entry_addrs),
        .i_tail(ex_tail),
        .i_count(ex_count),
        .i_head_tag(head_tag),
        .i_head_locked(head_locked),
        .o_lu_en(lu_en),
        .o_lu_we(lu_we),
        .o_lu_match(lu_match),
        .o_lu_tag(lu_tag),
        .o_lu_addr(lu_addr),
        .o_lu_offset(lu_offset),
        .o_lu_wr_data(lu_wr_data),
        .o_lu_bsel(lu_bsel),
        .o_lookup_done(o_lookup_done),
        .o_lookup_retry(o_lookup_retry)
    );

    mhq_ex #(
        .MHQ_DEPTH(MHQ_DEPTH)
    ) u_ex (
        .clk(clk),
        .i_reset(i_reset),
        .i_lu_en(lu_en),
        .i_lu_we(lu_we),
        .i_lu_match(lu_match),
        .i_lu_tag(lu_tag),
        .i_lu_addr(lu_addr),
        .i_lu_offset(lu_offset),
        .i_lu_wr_data(lu_wr_data),
        .i_lu_bsel(lu_bsel),
        .i_fill_retire(fill_retire),
        .o_valid_mask(ex_valid_mask),
        .o_entry_addrs(ex_entry_addrs),
        .o_tail(ex_tail),
        .o_count(ex_count),
        .o_head_valid(head_valid),
        .o_head_tag(head_tag),
        .o_head_addr(head_addr),
        .o_head_data(head_data),
        .o_head_mask(head_mask),
        .o_head_dirty(head_dirty)
    );

    mhq_fill #(
        .MHQ_DEPTH(MHQ_DEPTH)
    ) u_fill (
        .clk(clk),
        .i_reset(i_reset),
        .i_head_valid(head_valid),
        .i_head_tag(head_tag),
        .i_head_addr(head_addr),
        .i_head_data(head_data),
        .i_head_mask(head_mask),
        .i_head_dirty(head_dirty),
        .i_ccu_done(i_ccu_done),
        .i_ccu_data(i_ccu_data),
        .o_ccu_en(o_ccu_en),
        .o_ccu_addr(o_ccu_addr),
        .o_head_locked(head_locked),
        .o_fill_retire(fill_retire),
        .o_fill_en(o_fill_en),
        .o_fill_tag(o_fill_tag),
        .o_fill_addr(o_fill_addr),
        .o_fill_dirty(o_fill_dirty),
        .o_fill_data(o_fill_data)
    );

endmodule

/* bench/ccu_model.sv */
`timescale 1ns/1ps

module ccu_model #(
    parameter int unsigned SEED = 32'h1
) (
    input  logic                        clk,
    input  logic                        i_reset,
    input  logic                        i_hold,
    input  logic                        i_ccu_en,
    input  logic [mhq_pkg::ADDR_W-1:0]  i_ccu_addr,
    output logic                        o_ccu_done,
    output mhq_pkg::mhq_line_t          o_ccu_data
);

    logic           seeded = 1'b0;
    logic           busy;
    int unsigned    delay;

    // Byte k of a returned line is the line address plus k
    function automatic mhq_pkg::mhq_line_t line_pattern(input mhq_pkg::mhq_addr_t line);
        mhq_pkg::mhq_line_t pattern;
        for (int k = 0; k < mhq_pkg::LINE_BYTES; k++) begin
            pattern[k*8 +: 8] = line[7:0] + 8'(k);
        end
        return pattern;
    endfunction

    always @(posedge clk) begin
        if (!seeded) begin
            void'($urandom(SEED));
            seeded <= 1'b1;
        end
        if (i_reset) begin
            busy <= 1'b0;
            delay <= 0;
            o_ccu_done <= 1'b0;
            o_ccu_data <= '0;
        end else if (o_ccu_done) begin
            o_ccu_done <= 1'b0;
        end else if (busy) begin
            // The answer waits at the last count while the bench holds the CCU off
            if (delay > 1) begin
                delay <= delay - 1;
            end else if (!i_hold) begin
                o_ccu_done <= 1'b1;
                o_ccu_data <= line_pattern(i_ccu_addr[mhq_pkg::ADDR_W-1:mhq_pkg::OFFSET_W]);
                busy <= 1'b0;
            end
        end else if (i_ccu_en) begin
            busy <= 1'b1;
            delay <= 2 + ($urandom % 8);
        end
    end

endmodule

/* bench/mhq_tb.sv */
`timescale 1ns/1ps

module mhq_tb;

    localparam int DEPTH = 4;
    localparam int TAG_W = $clog2(DEPTH);
    localparam int unsigned RNG_SEED = 32'h78e8_50bf;
    localparam int DRAIN_LIMIT = 400;

    // A drain row releases the CCU and waits until every entry has been filled
    typedef struct packed {
        logic               drain;
        logic               hold;
        logic               dc_hit;
        logic [31:0]        addr;
        logic               we;
        logic [31:0]        data;
        logic [3:0]         bsel;
        logic               retry;
        logic [TAG_W-1:0]   tag;
    } step_t;

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       lookup_valid;
    logic                       lookup_dc_hit;
    logic [31:0]                lookup_addr;
    logic                       lookup_we;
    mhq_pkg::mhq_word_t         lookup_data;
    mhq_pkg::mhq_bsel_t         lookup_bsel;
    logic                       lookup_done;
    logic [TAG_W-1:0]           lookup_tag;
    logic                       lookup_retry;
    logic                       ccu_done;
    mhq_pkg::mhq_line_t         ccu_data;
    logic                       ccu_en;
    logic [31:0]                ccu_addr;
    logic                       ccu_hold;
    logic                       fill_en;
    logic [TAG_W-1:0]           fill_tag;
    logic [31:0]                fill_addr;
    logic                       fill_dirty;
    mhq_pkg::mhq_line_t         fill_data;

    logic [TAG_W-1:0]           exp_tag;
    logic                       exp_retry;
    logic                       prev_miss = 1'b0;
    logic [TAG_W-1:0]           prev_tag = '0;
    logic                       prev_retry = 1'b0;

    // Reference copy of the queue indexed by tag, with the live tags kept in allocation order
    mhq_pkg::mhq_addr_t         ref_line [DEPTH];
    mhq_pkg::mhq_mask_t         ref_mask [DEPTH];
    mhq_pkg::mhq_line_t         ref_data [DEPTH];
    logic                       ref_dirty [DEPTH];
    int                         fill_order [$];
    step_t                      steps [$];

    always #4 clk = ~clk;

    mhq #(
        .MHQ_DEPTH(DEPTH)
    ) u_mhq (
        .clk(clk),
        .i_reset(reset),
        .i_lookup_valid(lookup_valid),
        .i_lookup_dc_hit(lookup_dc_hit),
        .i_lookup_addr(lookup_addr),
        .i_lookup_we(lookup_we),
        .i_lookup_data(lookup_data),
        .i_lookup_bsel(lookup_bsel),
        .o_lookup_done(lookup_done),
        .o_lookup_tag(lookup_tag),
        .o_lookup_retry(lookup_retry),
        .i_ccu_done(ccu_done),
        .i_ccu_data(ccu_data),
        .o_ccu_en(ccu_en),
        .o_ccu_addr(ccu_addr),
        .o_fill_en(fill_en),
        .o_fill_tag(fill_tag),
        .o_fill_addr(fill_addr),
        .o_fill_dirty(fill_dirty),
        .o_fill_data(fill_data)
    );

    ccu_model #(
        .SEED(RNG_SEED)
    ) u_ccu (
        .clk(clk),
        .i_reset(reset),
        .i_hold(ccu_hold),
        .i_ccu_en(ccu_en),
        .i_ccu_addr(ccu_addr),
        .o_ccu_done(ccu_done),
        .o_ccu_data(ccu_data)
    );

    task automatic end_in_failure();
        $display("Result: FAILED");
        $fatal(1, "testbench stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] expected);
        $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end_in_failure();
    endtask

    task automatic report_error(input string what);
        $display("ERROR: %s", what);
        end_in_failure();
    endtask

    task automatic add_lookup(input logic hold, input logic dc_hit, input logic [31:0] addr,
                              input logic we, input logic [31:0] data, input logic [3:0] bsel,
                              input logic retry, input int tag);
        step_t s;
        s = '{1'b0, hold, dc_hit, addr, we, data, bsel, retry, TAG_W'(tag)};
        steps.push_back(s);
    endtask

    task automatic add_drain();
        step_t s;
        s = '{1'b1, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0, 4'h0, 1'b0, TAG_W'(0)};
        steps.push_back(s);
    endtask

    // Rows are applied on consecutive clocks, so a row sees the one before it in flight
    task automatic build_table();
        // CCU held off while the queue fills up
        add_lookup(1'b1, 1'b1, 32'h0000_1100, 1'b0, 32'h0000_0000, 4'b0000, 1'b0, 0);
        add_lookup(1'b1, 1'b0, 32'h0000_1100, 1'b0, 32'h0000_0000, 4'b0000, 1'b0, 0);
        add_lookup(1'b1, 1'b0, 32'h0000_1104, 1'b1, 32'ha1b2_c3d4, 4'b0011, 1'b0, 0);
        add_lookup(1'b1, 1'b0, 32'h0000_2200, 1'b0, 32'h0000_0000, 4'b0000, 1'b0, 1);
        add_lookup(1'b1, 1'b0, 32'h0000_2208, 1'b1, 32'h1122_3344, 4'b1111, 1'b0, 1);
        add_lookup(1'b1, 1'b0, 32'h0000_110c, 1'b1, 32'h5566_7788, 4'b1000, 1'b1, 0);
        add_lookup(1'b1, 1'b0, 32'h0000_3300, 1'b0, 32'h0000_0000, 4'b0000, 1'b0, 2);
        add_lookup(1'b1, 1'b0, 32'h0000_3300, 1'b1, 32'hdead_beef, 4'b0100, 1'b0, 2);
        add_lookup(1'b1, 1'b0, 32'h0000_4400, 1'b0, 32'h0000_0000, 4'b0000, 1'b0, 3);
        add_lookup(1'b1, 1'b0, 32'h0000_5500, 1'b0, 32'h0000_0000, 4'b0000, 1'b1, 0);
        add_lookup(1'b1, 1'b0, 32'h0000_6600, 1'b0, 32'h0000_0000, 4'b0000, 1'b1, 0);
        add_lookup(1'b1, 1'b0, 32'h0000_3304, 1'b0, 32'h0000_0000, 4'b0000, 1'b0, 2);
        add_lookup(1'b1, 1'b0, 32'h0000_4400, 1'b1, 32'h0f0e_0d0c, 4'b0001, 1'b0, 3);
        add_lookup(1'b1, 1'b0, 32'h0000_1100, 1'b0, 32'h0000_0000, 4'b0000, 1'b1, 0);
        add_drain();
        // The tail has wrapped to zero once the first round is gone
        add_lookup(1'b0, 1'b0, 32'h0000_7700, 1'b0, 32'h0000_0000, 4'b0000, 1'b0, 0);
        add_lookup(1'b0, 1'b0, 32'h0000_8814, 1'b1, 32'hcafe_f00d, 4'b1111, 1'b0, 1);
        add_lookup(1'b0, 1'b0, 32'h0000_9900, 1'b0, 32'h0000_0000, 4'b0000, 1'b0, 2);
        add_drain();
    endtask

    function automatic logic [7:0] ccu_byte(input mhq_pkg::mhq_addr_t line, input int k);
        return line[7:0] + 8'(k);
    endfunction

    // An accepted miss either merges into the live entry of its line or opens a new one
    task automatic record_lookup(input step_t s);
        int slot;
        int byte_idx;
        slot = -1;
        foreach (fill_order[i]) begin
            if (ref_line[fill_order[i]] == s.addr[31:4]) begin
                slot = fill_order[i];
            end
        end
        if (slot < 0) begin
            slot = int'(s.tag);
            ref_line[slot] = s.addr[31:4];
            ref_mask[slot] = '0;
            ref_data[slot] = '0;
            ref_dirty[slot] = 1'b0;
            fill_order.push_back(slot);
        end
        if (s.we) begin
            ref_dirty[slot] = 1'b1;
            for (int k = 0; k < 4; k++) begin
                byte_idx = int'(s.addr[3:2]) * 4 + k;
                if (s.bsel[k]) begin
                    ref_mask[slot][byte_idx] = 1'b1;
                    ref_data[slot][byte_idx*8 +: 8] = s.data[k*8 +: 8];
                end
            end
        end
    endtask

    task automatic check_fill(input int slot);
        mhq_pkg::mhq_line_t exp_line;
        for (int b = 0; b < 16; b++) begin
            if (ref_mask[slot][b]) begin
                exp_line[b*8 +: 8] = ref_data[slot][b*8 +: 8];
            end else begin
                exp_line[b*8 +: 8] = ccu_byte(ref_line[slot], b);
            end
        end
        assert (fill_tag == TAG_W'(slot))
            else report_mismatch("o_fill_tag", 128'(fill_tag), 128'(slot));
        assert (fill_addr == {ref_line[slot], 4'h0})
            else report_mismatch("o_fill_addr", 128'(fill_addr), 128'({ref_line[slot], 4'h0}));
        assert (fill_dirty == ref_dirty[slot])
            else report_mismatch("o_fill_dirty", 128'(fill_dirty), 128'(ref_dirty[slot]));
        assert (fill_data == exp_line)
            else report_mismatch("o_fill_data", fill_data, exp_line);
    endtask

    task automatic wait_for_fills();
        int cycles;
        cycles = 0;
        while (fill_order.size() != 0) begin
            @(posedge clk);
            cycles++;
            assert (cycles < DRAIN_LIMIT)
                else report_error("timeout waiting for the CCU fills to drain");
        end
    endtask

    // Done must follow each miss by exactly one clock, with the tag and retry of its row
    always @(negedge clk) begin
        if (!reset) begin
            assert (lookup_done == prev_miss)
                else report_mismatch("o_lookup_done", 128'(lookup_done), 128'(prev_miss));
            if (prev_miss) begin
                assert (lookup_retry == prev_retry)
                    else report_mismatch("o_lookup_retry", 128'(lookup_retry), 128'(prev_retry));
                if (!prev_retry) begin
                    assert (lookup_tag == prev_tag)
                        else report_mismatch("o_lookup_tag", 128'(lookup_tag), 128'(prev_tag));
                end
            end
        end
        prev_miss = lookup_valid && !lookup_dc_hit;
        prev_tag = exp_tag;
        prev_retry = exp_retry;
    end

    // Only the oldest outstanding line is requested from the CCU
    always @(negedge clk) begin
        if (!reset && ccu_en) begin
            assert (fill_order.size() != 0)
                else report_error("a CCU request came out with no entry outstanding");
            if (fill_order.size() != 0) begin
                assert (ccu_addr == {ref_line[fill_order[0]], 4'h0})
                    else report_mismatch("o_ccu_addr", 128'(ccu_addr),
                                         128'({ref_line[fill_order[0]], 4'h0}));
            end
        end
    end

    // Fills must come out in allocation order
    always @(negedge clk) begin
        if (!reset && fill_en) begin
            assert (fill_order.size() != 0)
                else report_error("a fill came out with no entry outstanding");
            if (fill_order.size() != 0) begin
                check_fill(fill_order.pop_front());
            end
        end
    end

    initial begin
        step_t s;
        reset = 1'b1;
        lookup_valid = 1'b0;
        lookup_dc_hit = 1'b0;
        lookup_addr = '0;
        lookup_we = 1'b0;
        lookup_data = '0;
        lookup_bsel = '0;
        ccu_hold = 1'b1;
        exp_tag = '0;
        exp_retry = 1'b0;
        build_table();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        foreach (steps[i]) begin
            s = steps[i];
            @(posedge clk);
            ccu_hold <= s.hold;
            if (s.drain) begin
                lookup_valid <= 1'b0;
                wait_for_fills();
            end else begin
                lookup_valid <= 1'b1;
                lookup_dc_hit <= s.dc_hit;
                lookup_addr <= s.addr;
                lookup_we <= s.we;
                lookup_data <= s.data;
                lookup_bsel <= s.bsel;
                exp_tag <= s.tag;
                exp_retry <= s.retry;
                if (!s.dc_hit && !s.retry) begin
                    record_lookup(s);
                end
            end
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* build.f */
src/mhq_pkg.sv
src/mhq_lu.sv
src/mhq_ex.sv
src/mhq_fill.sv
src/mhq.sv
bench/ccu_model.sv
bench/mhq_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the simulation with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module mhq_tb -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vmhq_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit "$status"
fi

exit 0
